/* sbk_pkg.sv */
// Shared types and sound CPU memory map; the ROM window covers codes 0 and 1, 16 kB in total
package sbk_pkg;

    // Data and address widths
    typedef logic        [ 7:0] byte_t;     // CPU data word
    typedef logic        [15:0] addr_t;     // Sound CPU address
    typedef logic        [13:0] rom_addr_t; // Shared ROM byte address
    typedef logic signed [15:0] level_t;    // Audio level and snd

    // PCM player FSM
    typedef enum logic [1:0] {
        idle,       // No run
        fetch,      // Buffer check, request issue
        wait_rom    // ROM access in flight
    } pcm_state_t;

    // Region codes on A[15:13]
    localparam logic [2:0] REG_BASE_ROM0   = 3'd0; // 0000
    localparam logic [2:0] REG_BASE_ROM1   = 3'd1; // 2000
    localparam logic [2:0] REG_BASE_RAM    = 3'd2; // 4000
    localparam logic [2:0] REG_BASE_LATCH  = 3'd3; // 6000
    localparam logic [2:0] REG_BASE_STATUS = 3'd4; // 8000
    localparam logic [2:0] REG_BASE_PAGE   = 3'd5; // A000
    localparam logic [2:0] REG_BASE_CTRL   = 3'd6; // C000
    localparam logic [2:0] REG_BASE_DAC    = 3'd7; // E000

    // Sample byte that ends a PCM run
    localparam byte_t PCM_END = 8'h00;

endpackage

/* sbk_rom_arb.sv */
// One ROM access in flight; a requester must hold req and addr until its ok pulse
`timescale 1ns/1ps

module sbk_rom_arb (
    input  logic               clk,
    input  logic               rst,
    // CPU requester
    input  logic               req_cpu,
    input  sbk_pkg::rom_addr_t addr_cpu,
    output logic               ok_cpu,
    // PCM requester
    input  logic               req_pcm,
    input  sbk_pkg::rom_addr_t addr_pcm,
    output logic               ok_pcm,
    output sbk_pkg::byte_t     rom_data_out,   // Valid with either ok
    // Shared ROM
    output logic               rom_cs,
    output sbk_pkg::rom_addr_t rom_addr,
    input  sbk_pkg::byte_t     rom_data,
    input  logic               rom_ok
);

    logic busy;
    logic owner_pcm;    // Current owner, 1 for PCM
    logic last_pcm;     // PCM got the last grant
    logic pick_pcm;
    logic grant;

    // Round robin between the two
    assign pick_pcm = req_pcm && (!req_cpu || !last_pcm);
    // No grant while an ok is out, so the old req is not seen again
    assign grant    = !busy && !ok_cpu && !ok_pcm && (req_cpu || req_pcm);
    assign rom_cs   = busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            owner_pcm <= 1'b0;
            last_pcm  <= 1'b0;
            ok_cpu    <= 1'b0;
            ok_pcm    <= 1'b0;
        end else begin
            ok_cpu <= 1'b0;
            ok_pcm <= 1'b0;
            if (grant) begin
                busy      <= 1'b1;
                owner_pcm <= pick_pcm;
            end else if (busy && rom_ok) begin
                busy     <= 1'b0;
                last_pcm <= owner_pcm;
                ok_cpu   <= !owner_pcm;     // Route back to owner
                ok_pcm   <= owner_pcm;
            end
        end
    end

    // Address and data payload
    always_ff @(posedge clk) begin
        if (grant)
            rom_addr <= pick_pcm ? addr_pcm : addr_cpu;
        if (busy && rom_ok)
            rom_data_out <= rom_data;
    end

endmodule

/* sbk_snd_decode.sv */
// Only one CPU access at a time; ROM writes are acknowledged and ignored; RAM_AW up to 13
`timescale 1ns/1ps

module sbk_snd_decode #(
    parameter int RAM_AW = 10
) (
    input  logic              clk,
    input  logic              rst,
    // Sound CPU bus
    input  logic              mreq_n,
    input  logic              wr_n,
    input  sbk_pkg::addr_t    cpu_addr,
    input  sbk_pkg::byte_t    cpu_dout,
    output sbk_pkg::byte_t    cpu_din,
    output logic              cpu_ok,
    // Main CPU side
    input  sbk_pkg::byte_t    main_dout,
    input  logic              m2s_data,
    input  logic              m2s_irq,
    output logic              snd_irq,
    // ROM requester
    output logic              rom_req_cpu,
    output sbk_pkg::rom_addr_t rom_addr_cpu,
    input  logic              rom_ok_cpu,
    input  sbk_pkg::byte_t    rom_data_cpu,
    // PCM and DAC control
    input  logic              pcm_busy,
    output sbk_pkg::byte_t    pcm_page,
    output logic              pcm_start,
    output logic              pcm_stop,
    output sbk_pkg::byte_t    dac_byte
);
    import sbk_pkg::*;

    byte_t      ram [2**RAM_AW];    // Work RAM
    byte_t      latch;              // Command from main CPU
    logic [2:0] region;
    logic       rom_sel;
    logic       acc_done;           // Current bus cycle already served
    logic       acc_go, acc_rd, acc_wr;
    logic       rom_start;

    assign region  = cpu_addr[15:13];
    assign rom_sel = (region == REG_BASE_ROM0) || (region == REG_BASE_ROM1);

    // New bus cycle, seen once
    assign acc_go    = !mreq_n && !acc_done && !rom_req_cpu;
    assign acc_rd    = acc_go && wr_n;
    assign acc_wr    = acc_go && !wr_n;
    assign rom_start = acc_rd && rom_sel;  // Only ROM reads go to the arbiter

    // Access state and handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_ok      <= 1'b0;
            acc_done    <= 1'b0;
            rom_req_cpu <= 1'b0;
        end else begin
            cpu_ok <= 1'b0;                 // Single cycle pulse
            if (mreq_n)
                acc_done <= 1'b0;           // Bus released
            if (rom_start) begin
                rom_req_cpu <= 1'b1;        // Held until ok
            end else if (acc_go) begin
                cpu_ok   <= 1'b1;           // Fixed one cycle latency
                acc_done <= 1'b1;
            end
            if (rom_req_cpu && rom_ok_cpu) begin
                rom_req_cpu <= 1'b0;
                cpu_ok      <= 1'b1;
                acc_done    <= 1'b1;
            end
        end
    end

    // ROM address latched with the request
    always_ff @(posedge clk) begin
        if (rom_start)
            rom_addr_cpu <= cpu_addr[13:0];
    end

    // Write registers and IRQ flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            latch     <= 8'h00;
            snd_irq   <= 1'b0;
            pcm_page  <= 8'h00;
            pcm_start <= 1'b0;
            pcm_stop  <= 1'b0;
            dac_byte  <= 8'h80;             // DAC mid scale means silence
        end else begin
            pcm_start <= acc_wr && (region == REG_BASE_CTRL) && cpu_dout[0];
            pcm_stop  <= acc_wr && (region == REG_BASE_CTRL) && cpu_dout[1];
            if (m2s_data)
                latch <= main_dout;
            if (m2s_irq)
                snd_irq <= 1'b1;            // Set wins over clear
            else if (acc_rd && (region == REG_BASE_LATCH))
                snd_irq <= 1'b0;            // Cleared by the latch read
            if (acc_wr && (region == REG_BASE_PAGE))
                pcm_page <= cpu_dout;
            if (acc_wr && (region == REG_BASE_DAC))
                dac_byte <= cpu_dout;
        end
    end

    // Synchronous RAM and registered read mux
    always_ff @(posedge clk) begin
        if (acc_wr && (region == REG_BASE_RAM))
            ram[cpu_addr[RAM_AW-1:0]] <= cpu_dout;
        if (rom_req_cpu && rom_ok_cpu) begin
            cpu_din <= rom_data_cpu;
        end else if (acc_rd) begin
            case (region)
                REG_BASE_RAM:    cpu_din <= ram[cpu_addr[RAM_AW-1:0]];
                REG_BASE_LATCH:  cpu_din <= latch;
                REG_BASE_STATUS: cpu_din <= {6'b111111, pcm_busy, snd_irq};
                default:         cpu_din <= 8'hff; // Write only or unmapped
            endcase
        end
    end

endmodule

/* sbk_pcm_player.sv */
// Byte-wide unsigned PCM; the ROM must refill the buffer faster than sample_cen empties it
`timescale 1ns/1ps

module sbk_pcm_player (
    input  logic               clk,
    input  logic               rst,
    input  logic               sample_cen,
    input  sbk_pkg::byte_t     pcm_page,
    input  logic               pcm_start,
    input  logic               pcm_stop,
    output logic               rom_req_pcm,
    output sbk_pkg::rom_addr_t rom_addr_pcm,
    input  logic               rom_ok_pcm,
    input  sbk_pkg::byte_t     rom_data,
    output logic               pcm_busy,
    output sbk_pkg::level_t    pcm_level
);
    import sbk_pkg::*;

    pcm_state_t state;
    rom_addr_t  nxt_addr;       // Next byte to fetch
    byte_t      buf_byte;       // Prefetch buffer
    logic       buf_valid;
    logic       discard;        // In-flight byte belongs to an aborted run
    logic       in_flight;

    // A request that cannot be dropped yet
    assign in_flight = (state == wait_rom) && !rom_ok_pcm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= idle;
            nxt_addr     <= '0;
            rom_addr_pcm <= '0;
            rom_req_pcm  <= 1'b0;
            buf_valid    <= 1'b0;
            discard      <= 1'b0;
            pcm_busy     <= 1'b0;
            pcm_level    <= '0;
        end else begin
            case (state)
                fetch: if (!buf_valid) begin
                    rom_req_pcm  <= 1'b1;
                    rom_addr_pcm <= nxt_addr;
                    state        <= wait_rom;
                end
                wait_rom: if (rom_ok_pcm) begin
                    rom_req_pcm <= 1'b0;
                    if (discard) begin
                        discard <= 1'b0;
                        state   <= pcm_busy ? fetch : idle;
                    end else begin
                        buf_valid <= 1'b1;
                        nxt_addr  <= nxt_addr + 1'b1;
                        state     <= fetch;
                    end
                end
                default: ;              // Idle until start
            endcase
            // Consume buffer, state is fetch here
            if (sample_cen && pcm_busy && buf_valid) begin
                buf_valid <= 1'b0;
                if (buf_byte == PCM_END) begin
                    pcm_busy  <= 1'b0;
                    pcm_level <= '0;
                    state     <= idle;
                end else begin
                    pcm_level <= {buf_byte ^ 8'h80, 8'h00};  // (b - 128) << 8
                end
            end
            // Restart or abort overrides the above
            if (pcm_start || pcm_stop) begin
                buf_valid <= 1'b0;
                pcm_level <= '0;
                pcm_busy  <= !pcm_stop;                     // Stop wins
                nxt_addr  <= {pcm_page, 6'd0};              // Page times 64
                discard   <= in_flight;
                if (!in_flight) begin
                    state       <= pcm_stop ? idle : fetch;
                    rom_req_pcm <= 1'b0;                    // Request not yet seen by the arbiter
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rom_ok_pcm)
            buf_byte <= rom_data;   // Qualified by buf_valid
    end

endmodule

/* sbk_mixer.sv */
// Sums at sample_cen only; no filtering, the output holds between sample pulses
`timescale 1ns/1ps

module sbk_mixer (
    input  logic            clk,
    input  logic            rst,
    input  logic            sample_cen,
    input  sbk_pkg::byte_t  dac_byte,
    input  sbk_pkg::level_t pcm_level,
    output sbk_pkg::level_t snd,
    output logic            sample,
    output logic            peak
);
    import sbk_pkg::*;

    byte_t              dac_off;    // Signed DAC value, b - 128
    logic signed [16:0] dac_ext;
    logic signed [16:0] pcm_ext;
    logic signed [16:0] sum;
    logic               ovf;
    level_t             sat;

    always_comb begin
        dac_off = dac_byte ^ 8'h80;
        dac_ext = {{2{dac_off[7]}}, dac_off, 7'd0};     // Shift left by 7
        pcm_ext = {pcm_level[15], pcm_level};
        sum     = dac_ext + pcm_ext;
        ovf     = sum[16] ^ sum[15];                    // Out of 16-bit range
        if (!ovf)
            sat = sum[15:0];
        else if (sum[16])
            sat = 16'h8000;                             // Clip low
        else
            sat = 16'h7fff;                             // Clip high
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd    <= '0;
            sample <= 1'b0;
            peak   <= 1'b0;
        end else begin
            sample <= sample_cen;
            peak   <= sample_cen && ovf;
            if (sample_cen)
                snd <= sat;
        end
    end

endmodule

/* sbk_snd_top.sv */
// Sound board without the Z80, PSG or speech chip; ROM and CPU bus handshakes are external
`timescale 1ns/1ps

module sbk_snd_top #(
    parameter int RAM_AW = 10    // 10 or 11
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               sample_cen,
    // Sound CPU bus
    input  logic               mreq_n,
    input  logic               wr_n,
    input  sbk_pkg::addr_t     cpu_addr,
    input  sbk_pkg::byte_t     cpu_dout,
    output sbk_pkg::byte_t     cpu_din,
    output logic               cpu_ok,
    // From main CPU
    input  sbk_pkg::byte_t     main_dout,
    input  logic               m2s_data,
    input  logic               m2s_irq,
    output logic               snd_irq,
    // Shared ROM
    output logic               rom_cs,
    output sbk_pkg::rom_addr_t rom_addr,
    input  sbk_pkg::byte_t     rom_data,
    input  logic               rom_ok,
    // Audio
    output sbk_pkg::level_t    snd,
    output logic               sample,
    output logic               peak
);
    import sbk_pkg::*;

    logic      rom_req_cpu, rom_ok_cpu;
    rom_addr_t rom_addr_cpu;
    logic      rom_req_pcm, rom_ok_pcm;
    rom_addr_t rom_addr_pcm;
    byte_t     arb_data;            // Shared by both requesters
    byte_t     pcm_page, dac_byte;
    logic      pcm_start, pcm_stop, pcm_busy;
    level_t    pcm_level;

    sbk_snd_decode #(.RAM_AW(RAM_AW)) u_decode (
        .clk(clk), .rst(rst),
        .mreq_n(mreq_n), .wr_n(wr_n), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .cpu_din(cpu_din), .cpu_ok(cpu_ok),
        .main_dout(main_dout), .m2s_data(m2s_data), .m2s_irq(m2s_irq), .snd_irq(snd_irq),
        .rom_req_cpu(rom_req_cpu), .rom_addr_cpu(rom_addr_cpu),
        .rom_ok_cpu(rom_ok_cpu), .rom_data_cpu(arb_data),
        .pcm_busy(pcm_busy), .pcm_page(pcm_page), .pcm_start(pcm_start),
        .pcm_stop(pcm_stop), .dac_byte(dac_byte)
    );

    sbk_rom_arb u_arb (
        .clk(clk), .rst(rst),
        .req_cpu(rom_req_cpu), .addr_cpu(rom_addr_cpu), .ok_cpu(rom_ok_cpu),
        .req_pcm(rom_req_pcm), .addr_pcm(rom_addr_pcm), .ok_pcm(rom_ok_pcm),
        .rom_data_out(arb_data),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok)
    );

    sbk_pcm_player u_pcm (
        .clk(clk), .rst(rst), .sample_cen(sample_cen),
        .pcm_page(pcm_page), .pcm_start(pcm_start), .pcm_stop(pcm_stop),
        .rom_req_pcm(rom_req_pcm), .rom_addr_pcm(rom_addr_pcm),
        .rom_ok_pcm(rom_ok_pcm), .rom_data(arb_data),
        .pcm_busy(pcm_busy), .pcm_level(pcm_level)
    );

    sbk_mixer u_mixer (
        .clk(clk), .rst(rst), .sample_cen(sample_cen),
        .dac_byte(dac_byte), .pcm_level(pcm_level),
        .snd(snd), .sample(sample), .peak(peak)
    );

endmodule

/* sbk_tb_chk.sv */
// ROM arbiter handshake checks, bound into every sbk_rom_arb; reset disables them
`timescale 1ns/1ps

module sbk_tb_chk (
    input logic               clk,
    input logic               rst,
    input logic               ok_cpu,
    input logic               ok_pcm,
    input logic               rom_cs,
    input logic               rom_ok,
    input sbk_pkg::rom_addr_t rom_addr
);

    // One owner per returned byte
    ok_excl: assert property (@(posedge clk) disable iff (rst) !(ok_cpu && ok_pcm))
        else $error("ok_cpu and ok_pcm high in the same cycle");

    // Address fixed for the whole access
    addr_hold: assert property (@(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok) |=> $stable(rom_addr))
        else $error("rom_addr moved while the ROM access was open");

    // Ok only after a finished ROM cycle
    ok_cause: assert property (@(posedge clk) disable iff (rst)
        (ok_cpu || ok_pcm) |-> $past(rom_cs && rom_ok))
        else $error("ok pulse without a preceding ROM access");

endmodule

bind sbk_rom_arb sbk_tb_chk u_chk (
    .clk(clk), .rst(rst), .ok_cpu(ok_cpu), .ok_pcm(ok_pcm),
    .rom_cs(rom_cs), .rom_ok(rom_ok), .rom_addr(rom_addr)
);

/* sbk_tb.sv */
// Plays the sound CPU, main CPU and ROM; sample_cen every 32 cycles keeps the PCM prefetch ahead
`timescale 1ns/1ps

module sbk_tb;
    import sbk_pkg::*;

    localparam int RAM_AW   = 10;
    localparam int CEN_DIV  = 32;           // Cycles between sample_cen pulses
    localparam int WAIT_MAX = 200;          // Cycles per wait before giving up

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        sample_cen = 1'b0;
    logic        mreq_n = 1'b1;
    logic        wr_n = 1'b1;
    logic        m2s_data = 1'b0;
    logic        m2s_irq = 1'b0;
    logic        rom_ok = 1'b0;
    addr_t       cpu_addr = '0;
    byte_t       cpu_dout = '0;
    byte_t       main_dout = '0;
    byte_t       rom_data = '0;
    byte_t       cpu_din;
    logic        cpu_ok, snd_irq, rom_cs, sample, peak;
    rom_addr_t   rom_addr;
    level_t      snd;
    byte_t       rom_mem [16384];           // ROM contents, also its model
    byte_t       ram_model [2**RAM_AW];
    logic [31:0] rnd_state = 32'd69059;     // Stimulus LCG
    logic [31:0] dly_state = ~32'd69059;    // ROM delay LCG, seed inverted
    int          rom_wait = 0;
    int          cen_cnt = 0;
    int          errors = 0;

    sbk_snd_top #(.RAM_AW(RAM_AW)) dut0 (
        .clk(clk), .rst(rst), .sample_cen(sample_cen),
        .mreq_n(mreq_n), .wr_n(wr_n), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .cpu_din(cpu_din), .cpu_ok(cpu_ok),
        .main_dout(main_dout), .m2s_data(m2s_data), .m2s_irq(m2s_irq), .snd_irq(snd_irq),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .snd(snd), .sample(sample), .peak(peak)
    );

    always #10 clk = ~clk;                  // 20 ns period

    // Sample clock enable, one cycle in CEN_DIV
    always @(posedge clk) begin
        #2;
        check_bit("sample", sample_cen, sample);    // One cycle behind sample_cen
        if (!sample)
            check_bit("peak", 1'b0, peak);          // Only with a sample
        cen_cnt    = (cen_cnt == CEN_DIV - 1) ? 0 : cen_cnt + 1;
        sample_cen = (cen_cnt == 0);
    end

    // ROM with 0 to 6 wait cycles per access
    always @(posedge clk) begin
        #2;
        if (rom_ok) begin
            rom_ok = 1'b0;                  // Single cycle ok
        end else if (rom_cs) begin
            if (rom_wait == 0) begin
                rom_ok    = 1'b1;
                rom_data  = rom_mem[rom_addr];
                dly_state = lcg_next(dly_state);
                rom_wait  = int'(dly_state[31:16]) % 7;
            end else begin
                rom_wait = rom_wait - 1;
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper LCG bits, below n
    function automatic int rand_below(input int n);
        rnd_state = lcg_next(rnd_state);
        return int'(rnd_state[31:16]) % n;
    endfunction

    // Mix rule: (dac - 128) * 128 + pcm, clipped to 16 bits
    function automatic level_t mix_model(input byte_t dac, input int pcm, output logic clip);
        int s;
        s    = (int'(dac) - 128) * 128 + pcm;
        clip = (s > 32767) || (s < -32768);
        if (s > 32767)
            s = 32767;
        else if (s < -32768)
            s = -32768;
        return level_t'(s);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;                                 // Drive and sample away from the edge
    endtask

    task automatic report_fail(input string why);
        errors++;
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp)
            report_fail($sformatf("ERR %0t %s expected %02h got %02h", $time, name, exp, act));
    endtask

    task automatic check_level(input string name, input level_t exp, input level_t act);
        if (act !== exp)
            report_fail($sformatf("ERR %0t %s expected %0d got %0d", $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_fail($sformatf("ERR %0t %s expected %b got %b", $time, name, exp, act));
    endtask

    // One sound CPU bus cycle, held until cpu_ok
    task automatic bus_cycle(input addr_t a, input logic wr, input byte_t wd, output byte_t rd);
        int n;
        cpu_addr = a;
        wr_n     = !wr;
        cpu_dout = wd;
        mreq_n   = 1'b0;
        n        = 0;
        next_cycle();
        if (a[15:13] > REG_BASE_ROM1)
            check_bit("cpu_ok", 1'b1, cpu_ok);  // Fixed latency outside the ROM window
        while (!cpu_ok && n < WAIT_MAX) begin
            next_cycle();
            n++;
        end
        if (!cpu_ok)
            report_fail("Timeout, the sound CPU bus never returned cpu_ok");
        rd     = cpu_din;
        mreq_n = 1'b1;
        next_cycle();                       // Bus idle for a cycle
        check_bit("cpu_ok", 1'b0, cpu_ok);  // Single cycle pulse
    endtask

    task automatic cpu_write(input addr_t a, input byte_t d);
        byte_t unused;
        bus_cycle(a, 1'b1, d, unused);
    endtask

    task automatic cpu_read(input addr_t a, output byte_t d);
        bus_cycle(a, 1'b0, 8'h00, d);
    endtask

    task automatic wait_sample();
        int n;
        n = 0;
        next_cycle();
        while (!sample && n < WAIT_MAX) begin
            next_cycle();
            n++;
        end
        if (!sample)
            report_fail("Timeout, no sample pulse from the mixer");
    endtask

    // Random run of len bytes at page, ended by PCM_END
    task automatic patch_run(input byte_t page, input int len);
        rom_addr_t ra;
        byte_t     b;
        int        i;
        ra = {page, 6'd0};
        for (i = 0; i < len; i++) begin
            b = byte_t'(rand_below(256));
            if (b == PCM_END || b == 8'h80)
                b = b + 8'h01;              // Never silent, never the end
            rom_mem[ra] = b;
            ra = ra + rom_addr_t'(1);
        end
        rom_mem[ra] = PCM_END;
    endtask

    task automatic rom_reads(input int cnt);
        addr_t a;
        byte_t d;
        int    i;
        for (i = 0; i < cnt; i++) begin
            a = addr_t'(rand_below(16384)); // Codes 0 and 1 form the ROM window
            cpu_read(a, d);
            check_byte("cpu_din rom", rom_mem[a[13:0]], d);
        end
    endtask

    // Plays the run at page and checks every sample pulse
    task automatic play_run(input byte_t page, input byte_t dac);
        byte_t     run [$];
        rom_addr_t ra;
        level_t    dac_only, exp;
        logic      clip;
        int        lead;
        byte_t     st;
        ra = {page, 6'd0};
        while (rom_mem[ra] != PCM_END) begin
            run.push_back(rom_mem[ra]);
            ra = ra + rom_addr_t'(1);
        end
        dac_only = mix_model(dac, 0, clip);
        cpu_write({REG_BASE_DAC, 13'd0}, dac);
        cpu_write({REG_BASE_PAGE, 13'd0}, page);
        cpu_write({REG_BASE_CTRL, 13'd0}, 8'h01);  // Start
        lead = 0;
        wait_sample();
        while (snd === dac_only && lead < 4) begin  // Before first byte
            lead++;
            wait_sample();
        end
        foreach (run[k]) begin
            exp = mix_model(dac, (int'(run[k]) - 128) * 256, clip);
            check_level("snd", exp, snd);
            check_bit("peak", clip, peak);
            wait_sample();
        end
        check_level("snd", dac_only, snd);         // DAC alone again
        check_bit("peak", 1'b0, peak);
        cpu_read({REG_BASE_STATUS, 13'd0}, st);
        check_byte("status", 8'hfc, st);           // Not busy, no irq
    endtask

    initial begin
        byte_t             d, page, dac;
        level_t            exp;
        logic              clip;
        logic [RAM_AW-1:0] wa;
        logic [RAM_AW-1:0] ram_addrs [$];
        logic [2:0]        wo_regs [3];
        rom_addr_t         ra;
        int                i;
        for (i = 0; i < 16384; i++)
            rom_mem[rom_addr_t'(i)] = byte_t'(rand_below(256));
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // RAM write then read back
        for (i = 0; i < 24; i++) begin
            wa = RAM_AW'(rand_below(2**RAM_AW));
            d  = byte_t'(rand_below(256));
            ram_model[wa] = d;
            ram_addrs.push_back(wa);
            cpu_write({REG_BASE_RAM, 13'(wa)}, d);
        end
        foreach (ram_addrs[k]) begin
            cpu_read({REG_BASE_RAM, 13'(ram_addrs[k])}, d);
            check_byte("cpu_din ram", ram_model[ram_addrs[k]], d);
        end

        // Main CPU latch, irq and status
        main_dout = byte_t'(rand_below(256));
        m2s_data  = 1'b1;
        m2s_irq   = 1'b1;
        next_cycle();
        m2s_data  = 1'b0;
        m2s_irq   = 1'b0;
        next_cycle();
        check_bit("snd_irq", 1'b1, snd_irq);
        cpu_read({REG_BASE_STATUS, 13'd0}, d);
        check_byte("status", 8'hfc | 8'h01, d);
        cpu_read({REG_BASE_LATCH, 13'(rand_below(8192))}, d);
        check_byte("latch", main_dout, d);
        check_bit("snd_irq", 1'b0, snd_irq);       // Cleared by the read
        cpu_read({REG_BASE_STATUS, 13'd0}, d);
        check_byte("status", 8'hfc, d);
        wo_regs = '{REG_BASE_PAGE, REG_BASE_CTRL, REG_BASE_DAC};
        foreach (wo_regs[k]) begin
            cpu_read({wo_regs[k], 13'(rand_below(8192))}, d);
            check_byte("cpu_din unmapped", 8'hff, d);
        end

        rom_reads(16);                             // PCM idle

        // Random run, then extremes with both DAC rails
        page = byte_t'(rand_below(256));
        patch_run(page, 8 + rand_below(24));
        play_run(page, byte_t'(rand_below(256)));
        ra = {page ^ 8'h55, 6'd0};
        rom_mem[ra]                    = 8'hff;
        rom_mem[ra + rom_addr_t'(1)]   = 8'h01;
        rom_mem[ra + rom_addr_t'(2)]   = 8'hc0;
        rom_mem[ra + rom_addr_t'(3)]   = 8'h40;
        rom_mem[ra + rom_addr_t'(4)]   = PCM_END;
        play_run(page ^ 8'h55, 8'hff);
        play_run(page ^ 8'h55, 8'h00);

        // ROM reads against playback, then stop mid run
        patch_run(page ^ 8'haa, 60);
        dac = byte_t'(rand_below(256));
        cpu_write({REG_BASE_DAC, 13'd0}, dac);
        cpu_write({REG_BASE_PAGE, 13'd0}, page ^ 8'haa);
        cpu_write({REG_BASE_CTRL, 13'd0}, 8'h01);
        rom_reads(16);
        cpu_read({REG_BASE_STATUS, 13'd0}, d);
        check_byte("status", 8'hfc | 8'h02, d);    // Still busy
        cpu_write({REG_BASE_CTRL, 13'd0}, 8'h02);  // Stop
        wait_sample();
        wait_sample();
        exp = mix_model(dac, 0, clip);
        check_level("snd", exp, snd);
        check_bit("peak", 1'b0, peak);
        cpu_read({REG_BASE_STATUS, 13'd0}, d);
        check_byte("status", 8'hfc, d);

        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* sbk_snd.f */
sbk_pkg.sv
sbk_rom_arb.sv
sbk_snd_decode.sv
sbk_pcm_player.sv
sbk_mixer.sv
sbk_snd_top.sv
sbk_tb_chk.sv
sbk_tb.sv

/* Makefile */
SIM      := verilator
TOP      := sbk_tb
FILELIST := sbk_snd.f
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Simulation finished: PASS
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
